/* compile.f */
design/uart_cmd_pkg.sv
design/uart_tx_link_if.sv
design/uart_rx_link_if.sv
design/uart_rx.sv
design/uart_cmd_sequencer.sv
design/uart_tx.sv
design/uart_cmd_bridge.sv
verification/clk_gen.sv
verification/uart_peer_model.sv
verification/tb_uart_cmd_bridge.sv

/* verification/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int     BIT_CLKS     = 8;
  localparam int     TIMEOUT_BITS = 20;
  localparam int     CLK_NS       = 40;
  localparam int     NUM_TESTS    = 12;
  localparam int     CMD_CYCLES   = (2 * uart_cmd_pkg::FRAME_BITS + TIMEOUT_BITS + 4) * BIT_CLKS;
  localparam longint LIMIT_NS     = longint'(NUM_TESTS) * CMD_CYCLES * CLK_NS +
                                    50 * BIT_CLKS * CLK_NS;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  logic [8:0]  read_data;
  int          peer_frames;
  int          peer_errs;

  // stimulus table and expected read results
  bit          tbl_rw   [$];
  bit [6:0]    tbl_addr [$];
  bit          tbl_bp   [$];
  bit [7:0]    tbl_data [$];
  bit [8:0]    tbl_exp  [$];
  logic [7:0]  shadow   [0:127];
  integer      seed;
  int          fail_checks;
  int          tests_ok;
  int          tests_bad;

  clk_gen #(.CLK_NS(CLK_NS), .RESET_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge #(
    .BIT_CLKS           (BIT_CLKS),
    .PARITY_ODD         (1),
    .REPLY_TIMEOUT_BITS (TIMEOUT_BITS)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  uart_peer_model #(.BIT_CLKS(BIT_CLKS), .PARITY_ODD(1)) peer (
    .clk         (clk),
    .line_in     (tx),
    .line_out    (rx),
    .frame_count (peer_frames),
    .err_count   (peer_errs)
  );

  task automatic add_entry(input bit rw, input bit [6:0] addr, input bit bp);
    tbl_rw.push_back(rw);
    tbl_addr.push_back(addr);
    tbl_bp.push_back(bp);
  endtask

  // expected reads follow the shadow registers
  task automatic build_table();
    logic [31:0] r;
    int          i;
    for (i = 0; i < 128; i++) begin
      shadow[i] = {i[6:0], 1'b0} ^ 8'h5b;
    end
    add_entry(0, 7'h10, 0);
    add_entry(0, 7'h22, 1);
    add_entry(0, 7'h10, 0);
    add_entry(1, 7'h10, 0);
    add_entry(1, 7'h22, 0);
    add_entry(1, 7'h7e, 0);
    add_entry(1, 7'h7f, 0);
    add_entry(0, 7'h05, 1);
    add_entry(1, 7'h05, 0);
    add_entry(1, 7'h33, 0);
    add_entry(0, 7'h33, 0);
    add_entry(1, 7'h33, 0);
    for (i = 0; i < NUM_TESTS; i++) begin
      r = $random(seed);
      tbl_data.push_back(tbl_rw[i] ? 8'h00 : r[7:0]);
      if (!tbl_rw[i]) begin
        shadow[tbl_addr[i]] = r[7:0];
        tbl_exp.push_back(9'h000);
      end else if (tbl_addr[i] == 7'h7f) begin
        tbl_exp.push_back(9'h100);
      end else begin
        tbl_exp.push_back({tbl_addr[i] == 7'h7e, shadow[tbl_addr[i]]});
      end
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
      fail_checks++;
      ok = 0;
    end
  endtask

  // a write ends on cmd_rdy and a read on read_rdy
  task automatic wait_done(input bit is_read, output bit seen, output bit early);
    int n;
    seen  = 0;
    early = 0;
    for (n = 0; n < CMD_CYCLES && !seen; n++) begin
      @(negedge clk);
      seen = is_read ? (read_rdy === 1'b1) : (cmd_rdy === 1'b1);
      if (is_read && !seen && cmd_rdy === 1'b1) begin
        early = 1;
      end
    end
  endtask

  task automatic run_test(input int idx);
    bit          ok;
    bit          seen;
    bit          early;
    int          frames0;
    logic [15:0] cmd;
    ok      = 1;
    cmd     = {tbl_rw[idx], tbl_addr[idx], tbl_data[idx]};
    frames0 = peer_frames;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_value("cmd_rdy", cmd_rdy, 0, ok);
    @(negedge clk);
    check_value("tx", tx, 0, ok);
    if (tbl_bp[idx]) begin
      // stray command while busy
      repeat (3 * BIT_CLKS) @(negedge clk);
      cmd_in  = ~cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      cmd_in  = cmd;
    end
    wait_done(tbl_rw[idx], seen, early);
    assert (seen) else begin
      $display("test %0d: the command did not complete within %0d cycles", idx, CMD_CYCLES);
      fail_checks++;
      ok = 0;
    end
    assert (!early) else begin
      $display("test %0d: cmd_rdy rose before read_rdy", idx);
      fail_checks++;
      ok = 0;
    end
    if (seen) begin
      if (tbl_rw[idx]) begin
        check_value("read_data", read_data, tbl_exp[idx], ok);
        check_value("cmd_rdy", cmd_rdy, 1, ok);
        @(negedge clk);
        check_value("read_rdy", read_rdy, 0, ok);
      end else begin
        check_value("peer.regs", peer.regs[tbl_addr[idx]], tbl_data[idx], ok);
      end
      check_value("peer_frames", peer_frames - frames0, tbl_rw[idx] ? 1 : 2, ok);
      check_value("peer_errs", peer_errs, 0, ok);
    end
    if (ok) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("test %0d %s addr 0x%02h: %s", idx, tbl_rw[idx] ? "read " : "write",
             tbl_addr[idx], ok ? "ok" : "mismatch");
  endtask

  initial begin
    bit ok;
    int i;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    seed        = 32'hb2dc;
    fail_checks = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    build_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    ok = 1;
    check_value("cmd_rdy", cmd_rdy, 1, ok);
    check_value("read_rdy", read_rdy, 0, ok);
    check_value("tx", tx, 1, ok);
    $display("reset state: %s", ok ? "ok" : "mismatch");
    for (i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    for (i = 0; i < 128; i++) begin
      assert (peer.regs[i] === shadow[i]) else begin
        $display("[ERROR] peer.regs[0x%02h]: expected 0x%02h, got 0x%02h",
                 i, shadow[i], peer.regs[i]);
        fail_checks++;
      end
    end
    $display("summary: %0d tests, %0d ok, %0d with mismatches, %0d failed checks",
             NUM_TESTS, tests_ok, tests_bad, fail_checks);
    if (fail_checks == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog: the run did not finish within %0d ns", LIMIT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

/* verification/uart_peer_model.sv */
`timescale 1ns/1ps

module uart_peer_model #(
  parameter int BIT_CLKS   = 8,
  parameter int PARITY_ODD = 1
) (
  input  logic clk,
  input  logic line_in,
  output logic line_out,
  output int   frame_count,
  output int   err_count
);

  localparam logic [6:0] BAD_PARITY_ADDR = 7'h7e;
  localparam logic [6:0] SILENT_ADDR     = 7'h7f;

  logic [7:0] regs [0:127];

  // hunts for a start bit, then samples each bit in its middle
  task automatic get_frame(output logic [7:0] data);
    logic par;
    int   i;
    @(negedge clk);
    while (line_in !== 1'b0) begin
      @(negedge clk);
    end
    repeat (BIT_CLKS / 2) @(negedge clk);
    if (line_in !== 1'b0) begin
      err_count++;
    end
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      data[i] = line_in;
    end
    repeat (BIT_CLKS) @(negedge clk);
    par = line_in;
    repeat (BIT_CLKS) @(negedge clk);
    if (par !== ((^data) ^ PARITY_ODD[0])) begin
      err_count++;
    end
    if (line_in !== 1'b1) begin
      err_count++;
    end
    frame_count++;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [9:0] bits;
    int         i;
    bits = {(^data) ^ PARITY_ODD[0] ^ bad_parity, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      line_out = bits[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    // half a stop bit of idle line before listening again
    line_out = 1'b1;
    repeat (BIT_CLKS / 2) @(negedge clk);
  endtask

  initial begin
    logic [7:0] addr_byte;
    logic [7:0] data_byte;
    int         a;
    line_out    = 1'b1;
    frame_count = 0;
    err_count   = 0;
    for (a = 0; a < 128; a++) begin
      regs[a] = {a[6:0], 1'b0} ^ 8'h5b;
    end
    // address byte is rw in bit 7 over the register address
    forever begin
      get_frame(addr_byte);
      if (!addr_byte[7]) begin
        get_frame(data_byte);
        regs[addr_byte[6:0]] = data_byte;
      end else if (addr_byte[6:0] != SILENT_ADDR) begin
        repeat (2 * BIT_CLKS) @(negedge clk);
        send_frame(regs[addr_byte[6:0]], addr_byte[6:0] == BAD_PARITY_ADDR);
      end
    end
  end

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
  parameter int CLK_NS       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* design/uart_cmd_bridge.sv */
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int BIT_CLKS           = 434,
  parameter int PARITY_ODD         = 1,
  parameter int REPLY_TIMEOUT_BITS = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_cmd_pkg::CMD_W-1:0] cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  input  logic                           rx,
  output logic                           tx,
  output logic                           read_rdy,
  output logic [uart_cmd_pkg::DATA_W:0]  read_data
);

  uart_tx_link_if tx_link ();
  uart_rx_link_if rx_link ();

  uart_rx #(
    .BIT_CLKS   (BIT_CLKS),
    .PARITY_ODD (PARITY_ODD)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .link  (rx_link)
  );

  uart_cmd_sequencer #(
    .BIT_CLKS           (BIT_CLKS),
    .REPLY_TIMEOUT_BITS (REPLY_TIMEOUT_BITS)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .tx_link   (tx_link),
    .rx_link   (rx_link)
  );

  uart_tx #(
    .BIT_CLKS   (BIT_CLKS),
    .PARITY_ODD (PARITY_ODD)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .link  (tx_link)
  );

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int BIT_CLKS   = 434,
  parameter int PARITY_ODD = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  output logic       tx,
  uart_tx_link_if.tx link
);

  localparam int CNT_W = (BIT_CLKS > 1) ? $clog2(BIT_CLKS) : 1;
  localparam int IDX_W = $clog2(uart_cmd_pkg::FRAME_BITS);
  localparam bit ODD   = (PARITY_ODD != 0);

  logic [uart_cmd_pkg::FRAME_BITS-1:0] frame;
  logic [CNT_W-1:0]                    bit_cnt;
  logic [IDX_W-1:0]                    bit_idx;
  logic                                parity;
  logic                                bit_end;
  logic                                last_bit;

  assign parity   = (^link.data_byte) ^ ODD;
  assign bit_end  = (bit_cnt == CNT_W'(BIT_CLKS - 1));
  assign last_bit = (bit_idx == IDX_W'(uart_cmd_pkg::FRAME_BITS - 1));

  // line is the low end of the frame register
  assign tx = frame[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame     <= '1;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      link.busy <= 1'b0;
      link.done <= 1'b0;
    end else begin
      link.done <= 1'b0;
      if (!link.busy) begin
        if (link.start) begin
          // stop, parity, data, start
          frame     <= {1'b1, parity, link.data_byte, 1'b0};
          bit_cnt   <= '0;
          bit_idx   <= '0;
          link.busy <= 1'b1;
        end
      end else if (bit_end) begin
        // shift in ones so the line idles high afterwards
        frame   <= {1'b1, frame[uart_cmd_pkg::FRAME_BITS-1:1]};
        bit_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        if (last_bit) begin
          link.busy <= 1'b0;
          link.done <= 1'b1;
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

/* design/uart_cmd_sequencer.sv */
`timescale 1ns/1ps

module uart_cmd_sequencer #(
  parameter int BIT_CLKS           = 434,
  parameter int REPLY_TIMEOUT_BITS = 16
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [uart_cmd_pkg::CMD_W-1:0]    cmd_in,
  input  logic                              cmd_vld,
  output logic                              cmd_rdy,
  output logic                              read_rdy,
  output logic [uart_cmd_pkg::DATA_W:0]     read_data,
  uart_tx_link_if.seq                       tx_link,
  uart_rx_link_if.seq                       rx_link
);

  localparam int TO_CLKS = REPLY_TIMEOUT_BITS * BIT_CLKS;
  localparam int TO_W    = (TO_CLKS > 1) ? $clog2(TO_CLKS) : 1;

  uart_cmd_pkg::seq_state_t        state;
  uart_cmd_pkg::cmd_t              cmd_new;
  uart_cmd_pkg::cmd_t              cmd_q;
  logic [uart_cmd_pkg::DATA_W-1:0] byte_q;
  logic                            start_q;
  logic [TO_W-1:0]                 wait_cnt;
  logic                            accept;
  logic                            timed_out;
  logic                            got_reply;
  logic                            reply_err;

  assign cmd_new = cmd_in;
  assign accept  = cmd_vld && cmd_rdy;

  assign timed_out = (state == uart_cmd_pkg::wait_reply) && !rx_link.start_seen &&
                     (wait_cnt == TO_W'(TO_CLKS - 1));
  assign got_reply = (state == uart_cmd_pkg::receive) && rx_link.valid;
  assign reply_err = timed_out || rx_link.parity_err || rx_link.stop_err;

  assign tx_link.data_byte = byte_q;
  assign tx_link.start     = start_q;

  // receiver only hunts for a start bit while a reply is due
  assign rx_link.enable = (state == uart_cmd_pkg::wait_reply);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_cmd_pkg::idle;
      cmd_rdy  <= 1'b1;
      read_rdy <= 1'b0;
      start_q  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      read_rdy <= 1'b0;
      // start holds until the transmitter takes it
      if (start_q && !tx_link.busy) begin
        start_q <= 1'b0;
      end
      case (state)
        uart_cmd_pkg::idle: begin
          if (accept) begin
            cmd_rdy <= 1'b0;
            start_q <= 1'b1;
            state   <= uart_cmd_pkg::send_addr;
          end
        end
        uart_cmd_pkg::send_addr: begin
          if (tx_link.done) begin
            if (cmd_q.rw) begin
              wait_cnt <= '0;
              state    <= uart_cmd_pkg::wait_reply;
            end else begin
              start_q <= 1'b1;
              state   <= uart_cmd_pkg::send_data;
            end
          end
        end
        uart_cmd_pkg::send_data: begin
          if (tx_link.done) begin
            cmd_rdy <= 1'b1;
            state   <= uart_cmd_pkg::idle;
          end
        end
        uart_cmd_pkg::wait_reply: begin
          if (rx_link.start_seen) begin
            state <= uart_cmd_pkg::receive;
          end else if (timed_out) begin
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= uart_cmd_pkg::idle;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        uart_cmd_pkg::receive: begin
          if (got_reply) begin
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= uart_cmd_pkg::idle;
          end
        end
        default: state <= uart_cmd_pkg::idle;
      endcase
    end
  end

  // command, outgoing byte and read result
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q  <= cmd_new;
      byte_q <= {cmd_new.rw, cmd_new.addr};
    end else if (state == uart_cmd_pkg::send_addr && tx_link.done && !cmd_q.rw) begin
      byte_q <= cmd_q.data;
    end
    if (timed_out || got_reply) begin
      read_data <= {reply_err, timed_out ? {uart_cmd_pkg::DATA_W{1'b0}} : rx_link.data_byte};
    end
  end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int BIT_CLKS   = 434,
  parameter int PARITY_ODD = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  uart_rx_link_if.rx link
);

  localparam int  CNT_W = (BIT_CLKS > 1) ? $clog2(BIT_CLKS) : 1;
  localparam int  IDX_W = $clog2(uart_cmd_pkg::FRAME_BITS);
  localparam int  HALF  = BIT_CLKS / 2;
  localparam bit  ODD   = (PARITY_ODD != 0);

  logic [2:0]                        rx_sync;
  logic                              rx_s;
  logic                              rx_prev;
  logic                              fall;
  logic                              active;
  logic [CNT_W-1:0]                  bit_cnt;
  logic [IDX_W-1:0]                  bit_idx;
  logic [uart_cmd_pkg::DATA_W-1:0]   shreg;
  logic                              par_bit;
  logic                              half_end;
  logic                              bit_end;

  assign rx_s     = rx_sync[2];
  assign fall     = rx_prev && !rx_s;
  assign half_end = (bit_cnt == CNT_W'(HALF - 1));
  assign bit_end  = (bit_cnt == CNT_W'(BIT_CLKS - 1));

  assign link.data_byte = shreg;

  // line idles high, so sync chain resets to ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 3'b111;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
      rx_prev <= rx_s;
    end
  end

  // bit_idx 0 is the start check, 1..8 data, 9 parity, 10 stop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active          <= 1'b0;
      bit_cnt         <= '0;
      bit_idx         <= '0;
      link.start_seen <= 1'b0;
      link.valid      <= 1'b0;
      link.parity_err <= 1'b0;
      link.stop_err   <= 1'b0;
    end else begin
      link.start_seen <= 1'b0;
      link.valid      <= 1'b0;
      if (!active) begin
        bit_cnt <= '0;
        bit_idx <= '0;
        if (link.enable && fall) begin
          active <= 1'b1;
        end
      end else if (bit_idx == '0) begin
        if (half_end) begin
          bit_cnt <= '0;
          if (!rx_s) begin
            bit_idx         <= IDX_W'(1);
            link.start_seen <= 1'b1;
          end else begin
            // glitch so back to hunting
            active <= 1'b0;
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (bit_end) begin
        bit_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == IDX_W'(uart_cmd_pkg::FRAME_BITS - 1)) begin
          active          <= 1'b0;
          link.valid      <= 1'b1;
          link.stop_err   <= !rx_s;
          link.parity_err <= ((^shreg) ^ ODD) != par_bit;
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // mid-bit samples with data arriving lsb first
  always_ff @(posedge clk) begin
    if (active && bit_end && bit_idx != '0) begin
      if (bit_idx <= IDX_W'(uart_cmd_pkg::DATA_W)) begin
        shreg <= {rx_s, shreg[uart_cmd_pkg::DATA_W-1:1]};
      end else if (bit_idx == IDX_W'(uart_cmd_pkg::DATA_W + 1)) begin
        par_bit <= rx_s;
      end
    end
  end

endmodule

/* design/uart_rx_link_if.sv */
`timescale 1ns/1ps

interface uart_rx_link_if;

  logic [uart_cmd_pkg::DATA_W-1:0] data_byte;
  logic                            valid;
  logic                            parity_err;
  logic                            stop_err;
  logic                            start_seen;
  logic                            enable;

  modport rx (
    output data_byte,
    output valid,
    output parity_err,
    output stop_err,
    output start_seen,
    input  enable
  );

  modport seq (
    input  data_byte,
    input  valid,
    input  parity_err,
    input  stop_err,
    input  start_seen,
    output enable
  );

endinterface

/* design/uart_tx_link_if.sv */
`timescale 1ns/1ps

interface uart_tx_link_if;

  logic [uart_cmd_pkg::DATA_W-1:0] data_byte;
  logic                            start;
  logic                            busy;
  logic                            done;

  modport seq (
    output data_byte,
    output start,
    input  busy,
    input  done
  );

  modport tx (
    input  data_byte,
    input  start,
    output busy,
    output done
  );

endinterface

/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // command word and serial frame layout
  localparam int CMD_W      = 16;
  localparam int ADDR_W     = 7;
  localparam int DATA_W     = 8;

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  // rw = 1 is a read
  typedef struct packed {
    logic              rw;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cmd_t;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    send_data,
    wait_reply,
    receive
  } seq_state_t;

endpackage
